//--- hdl/cart_pkg.sv
// limits: ROM up to 8 MiB (512 banks), cartridge RAM up to 128 KiB, loader words are 16 bit
`default_nettype none

package cart_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int ROM_BANK_W  = 9;  // 512 banks of 16 KiB
	localparam int RAM_BANK_W  = 4;  // 16 banks of 8 KiB
	localparam int MAP_BANK_W  = 10; // 8 KiB half-bank index into ROM
	localparam int ROM_WADDR_W = 22; // 16-bit word address, 8 MiB
	localparam int CRAM_AW     = 17; // byte address, 128 KiB
	localparam int LOAD_AW     = 25; // loader byte address

	// header word offsets with the wanted byte in the high half
	localparam logic [LOAD_AW-1:0] HDR_CGB_OFS  = 25'h142; // 0x143 colour flag
	localparam logic [LOAD_AW-1:0] HDR_TYPE_OFS = 25'h146; // 0x147 cartridge type
	localparam logic [LOAD_AW-1:0] HDR_SIZE_OFS = 25'h148; // 0x148 rom size, 0x149 ram size

	// ------------------------------------------------------------------
	// 8 KiB region codes (a15:a13)
	// ------------------------------------------------------------------
	localparam logic [2:0] REG_RAMEN   = 3'd0; // 0000-1fff ram enable
	localparam logic [2:0] REG_ROMBANK = 3'd1; // 2000-3fff rom bank
	localparam logic [2:0] REG_RAMBANK = 3'd2; // 4000-5fff ram bank / rtc select
	localparam logic [2:0] REG_MODE    = 3'd3; // 6000-7fff mbc1 banking mode
	localparam logic [2:0] REG_CRAM    = 3'd5; // a000-bfff external ram window

	localparam logic [3:0] RAM_ENABLE_KEY = 4'ha; // low nibble that opens the ram

	// ------------------------------------------------------------------
	// cpu cartridge address seen either as a region select
	// or as a rom word pointer
	// ------------------------------------------------------------------
	typedef union packed {
		struct packed {
			logic [2:0]  region; // a15:a13
			logic [12:0] offset; // a12:a0, byte within the window
		} rgn;
		struct packed {
			logic [1:0]  quadrant; // a15:a14, 16 KiB slot
			logic        bank_lo;  // a13, which half of the bank
			logic [11:0] word;     // a12:a1
			logic        lane;     // a0, byte of the rom word
		} rom;
	} cart_addr_u;

endpackage

`default_nettype wire

//--- hdl/cart_header.sv
// header bytes are captured only while load_active; unknown rom sizes fall back to 128 banks
`default_nettype none

module cart_header (
	input  wire                              clk_sys,
	input  wire                              reset,
	input  wire                              load_active,
	input  wire                              load_wr,
	input  wire [cart_pkg::LOAD_AW-1:0]      load_addr,
	input  wire [15:0]                       load_data,
	output logic                             mbc1,
	output logic                             mbc2,
	output logic                             mbc3,
	output logic                             mbc5,
	output logic [cart_pkg::ROM_BANK_W-1:0]  rom_mask,
	output logic [cart_pkg::RAM_BANK_W-1:0]  ram_mask,
	output logic                             cgb_game,
	output logic                             cart_ready
);
	import cart_pkg::*;

	logic [7:0] cart_type; // 0x147
	logic [7:0] rom_size;  // 0x148
	logic [7:0] ram_size;  // 0x149
	logic [7:0] cgb_flag;  // 0x143
	logic       load_q;    // load_active one cycle late

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type  <= '0; // no controller
			rom_size   <= '0;
			ram_size   <= '0;
			cgb_flag   <= '0;
			load_q     <= 1'b0;
			cart_ready <= 1'b0;
		end else begin
			load_q <= load_active;
			if (load_active)
				cart_ready <= 1'b0; // image changing under us
			else if (load_q)
				cart_ready <= 1'b1; // load just ended
			if (load_active && load_wr) begin
				case (load_addr)
					HDR_CGB_OFS:  cgb_flag <= load_data[15:8];
					HDR_TYPE_OFS: cart_type <= load_data[15:8];
					HDR_SIZE_OFS: {ram_size, rom_size} <= load_data;
					default: ; // ordinary rom data
				endcase
			end
		end
	end

	// controller kind from the type byte
	assign mbc1 = (cart_type >= 8'd1) && (cart_type <= 8'd3);
	assign mbc2 = (cart_type == 8'd5) || (cart_type == 8'd6);
	assign mbc3 = (cart_type >= 8'd15) && (cart_type <= 8'd19); // 0x0f-0x13
	assign mbc5 = (cart_type >= 8'd25) && (cart_type <= 8'd30); // 0x19-0x1e

	assign cgb_game = (cgb_flag == 8'h80) || (cgb_flag == 8'hc0);

	always_comb begin
		// 2^(n+1) banks -> mask of n+1 ones
		if (rom_size <= 8'd8)
			rom_mask = {ROM_BANK_W{1'b1}} >> (4'd8 - rom_size[3:0]);
		else
			rom_mask = ROM_BANK_W'(7'h7f); // odd sizes 0x52-0x54 and junk
		case (ram_size)
			8'd0, 8'd1, 8'd2: ram_mask = 4'b0000; // one bank or none
			8'd3:             ram_mask = 4'b0011; // 32 KiB
			default:          ram_mask = 4'b1111; // 128 KiB
		endcase
	end

	// a header word written outside a load would be dropped silently
	a_load_wr_in_load: assert property (@(posedge clk_sys) disable iff (reset)
		load_wr |-> load_active)
		else $error("load_wr high outside load_active");

endmodule

`default_nettype wire

//--- hdl/mbc_regs.sv
// registers follow the cpu write strobe on every clk_sys edge; rtc registers themselves are absent
`default_nettype none

module mbc_regs (
	input  wire                              clk_sys,
	input  wire                              reset,
	input  wire                              load_active,
	input  wire                              cart_wr,
	input  cart_pkg::cart_addr_u             cart_addr,
	input  wire [7:0]                        cart_di,
	input  wire                              mbc1,
	input  wire                              mbc3,
	input  wire                              mbc5,
	output logic [cart_pkg::ROM_BANK_W-1:0]  rom_bank,
	output logic [cart_pkg::RAM_BANK_W-1:0]  ram_bank,
	output logic                             mbc1_mode,
	output logic                             rtc_mode,
	output logic                             ram_enable
);
	import cart_pkg::*;

	logic [2:0] region;
	logic       wr_ramen;
	logic       wr_rombank;
	logic       wr_rambank;
	logic       wr_mode;

	assign region     = cart_addr.rgn.region;
	assign wr_ramen   = cart_wr && (region == REG_RAMEN);
	assign wr_rombank = cart_wr && (region == REG_ROMBANK);
	assign wr_rambank = cart_wr && (region == REG_RAMBANK);
	assign wr_mode    = cart_wr && (region == REG_MODE);

	// ------------------------------------------------------------------
	// register file
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || load_active) begin
			rom_bank   <= ROM_BANK_W'(1); // bank 1 sits at 4000 after power up
			ram_bank   <= '0;
			mbc1_mode  <= 1'b0;
			rtc_mode   <= 1'b0;
			ram_enable <= 1'b0;
		end else begin
			if (wr_ramen)
				ram_enable <= (cart_di[3:0] == RAM_ENABLE_KEY);

			if (wr_rombank) begin
				if (mbc5) begin
					if (cart_addr.rgn.offset[12]) // 3000-3fff
						rom_bank[8] <= cart_di[0];
					else                          // 2000-2fff
						rom_bank[7:0] <= cart_di;
				end else if (cart_di[6:0] == 7'd0) begin
					rom_bank <= ROM_BANK_W'(1); // bank 0 not selectable here
				end else begin
					rom_bank <= {2'b00, cart_di[6:0]};
				end
			end

			if (wr_rambank) begin
				if (mbc3) begin
					if (cart_di[3]) begin
						rtc_mode <= 1'b1; // 08-0c pick an rtc register
					end else begin
						rtc_mode <= 1'b0;
						ram_bank <= {2'b00, cart_di[1:0]};
					end
				end else if (mbc5) begin
					ram_bank <= cart_di[3:0];
				end else begin
					ram_bank <= {2'b00, cart_di[1:0]}; // mbc1 upper bits
				end
			end

			if (wr_mode && mbc1)
				mbc1_mode <= cart_di[0]; // 1 = ram banking mode
		end
	end

	// bank 0 in the switched slot is only legal on mbc5; the flag comes from the header
	a_rom_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		!mbc5 |-> (rom_bank != '0))
		else $error("rom bank 0 selected on a non-mbc5 cartridge");

endmodule

`default_nettype wire

//--- hdl/bank_map.sv
// pure combinational decode; no controller means a flat 32 KiB rom and one 8 KiB ram bank
`default_nettype none

module bank_map (
	input  cart_pkg::cart_addr_u             cart_addr,
	input  wire                              mbc1,
	input  wire                              mbc2,
	input  wire                              mbc3,
	input  wire                              mbc5,
	input  wire [cart_pkg::ROM_BANK_W-1:0]   rom_bank,
	input  wire [cart_pkg::RAM_BANK_W-1:0]   ram_bank,
	input  wire                              mbc1_mode,
	input  wire [cart_pkg::ROM_BANK_W-1:0]   rom_mask,
	input  wire [cart_pkg::RAM_BANK_W-1:0]   ram_mask,
	output logic [cart_pkg::ROM_WADDR_W-1:0] rom_addr,
	output logic                             rom_hi,
	output logic [cart_pkg::CRAM_AW-1:0]     cram_addr
);
	import cart_pkg::*;

	logic [6:0]            mbc1_bank; // ram bank bits act as rom a20:a19 in mode 0
	logic [ROM_BANK_W-1:0] sw_bank;   // bank seen at 4000-7fff
	logic [MAP_BANK_W-1:0] half_bank; // 8 KiB slice of the rom
	logic [RAM_BANK_W-1:0] cram_bank;
	logic                  any_mbc;

	assign any_mbc   = mbc1 | mbc2 | mbc3 | mbc5;
	assign mbc1_bank = {mbc1_mode ? 2'b00 : ram_bank[1:0], rom_bank[4:0]};

	// ------------------------------------------------------------------
	// rom side
	// ------------------------------------------------------------------
	always_comb begin
		if (mbc5)
			sw_bank = rom_bank & rom_mask; // full 9 bits
		else if (mbc1)
			sw_bank = {2'b00, mbc1_bank & rom_mask[6:0]};
		else
			sw_bank = {2'b00, rom_bank[6:0] & rom_mask[6:0]}; // mbc2 / mbc3

		if (!any_mbc)
			half_bank = {8'd0, cart_addr.rom.quadrant[0], cart_addr.rom.bank_lo}; // a14:a13
		else if (cart_addr.rom.quadrant == 2'd0)
			half_bank = {9'd0, cart_addr.rom.bank_lo}; // fixed bank 0
		else if (cart_addr.rom.quadrant == 2'd1)
			half_bank = {sw_bank, cart_addr.rom.bank_lo};
		else
			half_bank = '0; // not a rom access
	end

	assign rom_addr = {half_bank, cart_addr.rom.word};
	assign rom_hi   = cart_addr.rom.lane; // odd byte lives in the high lane

	// ------------------------------------------------------------------
	// ram side
	// ------------------------------------------------------------------
	always_comb begin
		if ((mbc1 && mbc1_mode) || mbc3)
			cram_bank = {2'b00, ram_bank[1:0] & ram_mask[1:0]};
		else if (mbc5)
			cram_bank = ram_bank & ram_mask;
		else
			cram_bank = '0; // mbc1 mode 0, mbc2, plain rom
	end

	assign cram_addr = {cram_bank, cart_addr.rgn.offset};

endmodule

`default_nettype wire

//--- hdl/cart_ram.sv
// rom_q must be valid in the cycle of cart_rd; ram is volatile, no battery save path
`default_nettype none

module cart_ram (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          cart_rd,
	input  wire                          cart_wr,
	input  cart_pkg::cart_addr_u         cart_addr,
	input  wire [7:0]                    cart_di,
	input  wire [cart_pkg::CRAM_AW-1:0]  cram_addr,
	input  wire [15:0]                   rom_q,
	input  wire                          rom_hi,
	input  wire                          ram_enable,
	input  wire                          rtc_mode,
	input  wire                          mbc2,
	input  wire                          cart_ready,
	output logic [7:0]                   cart_do
);
	import cart_pkg::*;

	logic [7:0] ram_lo [0:65535]; // even bytes
	logic [7:0] ram_hi [0:65535]; // odd bytes

	logic [15:0] lane_addr;
	logic        is_cram;
	logic [7:0]  cram_q;
	logic        mbc2_area;

	assign lane_addr = cram_addr[CRAM_AW-1:1];
	assign is_cram   = (cart_addr.rgn.region == REG_CRAM);
	assign cram_q    = cram_addr[0] ? ram_hi[lane_addr] : ram_lo[lane_addr];
	assign mbc2_area = mbc2 && (cart_addr.rgn.offset[12:9] == 4'd0); // a000-a1ff, 512 x 4 bit

	// ------------------------------------------------------------------
	// ram write with the lane picked by a0 of the mapped address
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cart_wr && is_cram) begin
			if (cram_addr[0])
				ram_hi[lane_addr] <= cart_di;
			else
				ram_lo[lane_addr] <= cart_di;
		end
	end

	// read data register holds until the next read
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_do <= 8'h00;
		end else if (cart_rd) begin
			if (!cart_ready)
				cart_do <= 8'h00; // no image yet
			else if (is_cram) begin
				if (!ram_enable)
					cart_do <= 8'hff; // bus floats high
				else if (mbc2_area)
					cart_do <= {4'hf, cram_q[3:0]}; // only low nibble exists
				else if (rtc_mode)
					cart_do <= 8'h00;
				else
					cart_do <= cram_q;
			end else begin
				cart_do <= rom_hi ? rom_q[15:8] : rom_q[7:0];
			end
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(cart_rd && cart_wr))
		else $error("cart_rd and cart_wr high together");

endmodule

`default_nettype wire

//--- hdl/gb_cart_mapper.sv
// rom is external and must answer rom_addr combinationally; reads return zero until cart_ready
`default_nettype none

module gb_cart_mapper (
	input  wire                              clk_sys,
	input  wire                              reset,
	input  wire                              load_active,
	input  wire                              load_wr,
	input  wire [cart_pkg::LOAD_AW-1:0]      load_addr,
	input  wire [15:0]                       load_data,
	input  cart_pkg::cart_addr_u             cart_addr,
	input  wire                              cart_rd,
	input  wire                              cart_wr,
	input  wire [7:0]                        cart_di,
	input  wire [15:0]                       rom_q,
	output logic [7:0]                       cart_do,
	output logic [cart_pkg::ROM_WADDR_W-1:0] rom_addr,
	output logic                             cgb_game,
	output logic                             cart_ready
);
	import cart_pkg::*;

	logic                  mbc1, mbc2, mbc3, mbc5;
	logic [ROM_BANK_W-1:0] rom_mask;
	logic [RAM_BANK_W-1:0] ram_mask;
	logic [ROM_BANK_W-1:0] rom_bank;
	logic [RAM_BANK_W-1:0] ram_bank;
	logic                  mbc1_mode;
	logic                  rtc_mode;
	logic                  ram_enable;
	logic                  rom_hi;
	logic [CRAM_AW-1:0]    cram_addr;

	// ------------------------------------------------------------------
	// header -> registers -> address map -> ram / read mux
	// ------------------------------------------------------------------
	cart_header u_header (
		.clk_sys, .reset, .load_active, .load_wr, .load_addr, .load_data,
		.mbc1, .mbc2, .mbc3, .mbc5, .rom_mask, .ram_mask, .cgb_game, .cart_ready
	);

	mbc_regs u_regs (
		.clk_sys, .reset, .load_active, .cart_wr, .cart_addr, .cart_di,
		.mbc1, .mbc3, .mbc5,
		.rom_bank, .ram_bank, .mbc1_mode, .rtc_mode, .ram_enable
	);

	bank_map u_map (
		.cart_addr, .mbc1, .mbc2, .mbc3, .mbc5,
		.rom_bank, .ram_bank, .mbc1_mode, .rom_mask, .ram_mask,
		.rom_addr, .rom_hi, .cram_addr
	);

	cart_ram u_ram (
		.clk_sys, .reset, .cart_rd, .cart_wr, .cart_addr, .cart_di, .cram_addr,
		.rom_q, .rom_hi, .ram_enable, .rtc_mode, .mbc2, .cart_ready, .cart_do
	);

endmodule

`default_nettype wire

//--- sim/tb_gb_cart_mapper.sv
// rom model answers in the same cycle; cart_ready waits time out after 100 cycles
`default_nettype none

module tb_gb_cart_mapper;
	import cart_pkg::*;

	localparam int OP_IMAGE = 0; // header load with addr = {flag, type} and data = {ram size, rom size}
	localparam int OP_WR    = 1; // cpu write of a literal byte
	localparam int OP_RAMWR = 2; // cpu write of a random byte kept in slot data
	localparam int OP_RD    = 3; // cpu read against a literal byte
	localparam int OP_RDROM = 4; // cpu read with an expected rom word address
	localparam int OP_RAMRD = 5; // cpu read of the byte kept in slot data
	localparam int READY_TIMEOUT = 100;

	logic                   clk_sys;
	logic                   reset;
	logic                   load_active;
	logic                   load_wr;
	logic [LOAD_AW-1:0]     load_addr;
	logic [15:0]            load_data;
	cart_addr_u             cart_addr;
	logic                   cart_rd;
	logic                   cart_wr;
	logic [7:0]             cart_di;
	logic [15:0]            rom_q;
	logic [7:0]             cart_do;
	logic [ROM_WADDR_W-1:0] rom_addr;
	logic                   cgb_game;
	logic                   cart_ready;

	int                     op_q[$];   // stimulus table with one entry per row
	logic [15:0]            addr_q[$];
	logic [15:0]            data_q[$];
	logic [7:0]             exp_q[$];
	logic [ROM_WADDR_W-1:0] ra_q[$];
	logic [7:0]             slot_byte [0:7]; // random ram bytes awaiting readback
	logic [31:0]            rng_state;

	gb_cart_mapper dut (
		.clk_sys, .reset, .load_active, .load_wr, .load_addr, .load_data,
		.cart_addr, .cart_rd, .cart_wr, .cart_di, .rom_q,
		.cart_do, .rom_addr, .cgb_game, .cart_ready
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ------------------------------------------------------------------
	// models and helpers
	// ------------------------------------------------------------------
	function automatic logic [15:0] rom_word(input logic [ROM_WADDR_W-1:0] a);
		return {a[7:0] + 8'd1, a[7:0]}; // odd byte one above the even byte
	endfunction

	assign rom_q = rom_word(rom_addr); // answers in the same cycle

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s, got %02h expected %02h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_rom_addr(input logic [ROM_WADDR_W-1:0] got,
			input logic [ROM_WADDR_W-1:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s, got %06h expected %06h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s, got %b expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic loader_word(input logic [LOAD_AW-1:0] a, input logic [15:0] d);
		@(negedge clk_sys);
		load_wr   = 1'b1;
		load_addr = a;
		load_data = d; // wanted byte sits in the high half
	endtask

	task automatic load_image(input logic [7:0] flag, input logic [7:0] kind,
			input logic [15:0] sizes);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		load_active = 1'b1;
		loader_word(HDR_CGB_OFS, {flag, 8'h00});
		loader_word(HDR_TYPE_OFS, {kind, 8'h00});
		loader_word(HDR_SIZE_OFS, sizes);
		@(negedge clk_sys);
		load_wr     = 1'b0;
		load_active = 1'b0;
		while (!cart_ready && waited < READY_TIMEOUT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!cart_ready) begin
			$display("cart_ready did not rise within %0d cycles after the load", READY_TIMEOUT);
			stop_run();
		end
	endtask

	task automatic apply_row(input int op, input logic [15:0] addr, input logic [15:0] data,
			input logic [7:0] exp_byte, input logic [ROM_WADDR_W-1:0] exp_ra);
		logic [15:0] word;
		if (op == OP_IMAGE) begin
			load_image(addr[15:8], addr[7:0], data);
			check_bit(cgb_game, exp_byte[0], "cgb_game after load");
		end else begin
			@(negedge clk_sys);
			cart_addr = addr;
			case (op)
				OP_WR: begin
					cart_wr = 1'b1;
					cart_di = data[7:0];
				end
				OP_RAMWR: begin
					rng_state = xorshift(rng_state);
					slot_byte[data[2:0]] = rng_state[7:0];
					cart_wr = 1'b1;
					cart_di = rng_state[7:0];
				end
				default: cart_rd = 1'b1; // every read kind
			endcase
			@(negedge clk_sys); // cart_do registered and cart_addr still held
			cart_wr = 1'b0;
			cart_rd = 1'b0;
			case (op)
				OP_RD: check_byte(cart_do, exp_byte, $sformatf("read of %04h", addr));
				OP_RAMRD: check_byte(cart_do, slot_byte[data[2:0]],
					$sformatf("ram read of %04h", addr));
				OP_RDROM: begin
					check_rom_addr(rom_addr, exp_ra, $sformatf("rom_addr for %04h", addr));
					word = rom_word(exp_ra);
					check_byte(cart_do, addr[0] ? word[15:8] : word[7:0],
						$sformatf("rom read of %04h", addr));
				end
				default: ; // writes only
			endcase
		end
	endtask

	task automatic add_row(input int op, input logic [15:0] addr, input logic [15:0] data,
			input logic [7:0] exp_byte, input logic [ROM_WADDR_W-1:0] exp_ra);
		op_q.push_back(op);
		addr_q.push_back(addr);
		data_q.push_back(data);
		exp_q.push_back(exp_byte);
		ra_q.push_back(exp_ra);
	endtask

	// ------------------------------------------------------------------
	// stimulus table with op, addr, data, expected byte and expected rom word address
	// ------------------------------------------------------------------
	task automatic build_table();
		add_row(OP_RD,    16'h0150, 16'h0000, 8'h00, '0); // nothing loaded yet
		add_row(OP_IMAGE, 16'h8003, 16'h0305, 8'h01, '0); // mbc1, 64 banks, 32 KiB ram, cgb
		add_row(OP_WR,    16'h2000, 16'h0000, 8'h00, '0); // bank 0 turns into 1
		add_row(OP_RDROM, 16'h4002, 16'h0000, 8'h00, 22'h002001);
		add_row(OP_WR,    16'h4000, 16'h0001, 8'h00, '0); // mode 0 with rom bits 6:5
		add_row(OP_WR,    16'h2000, 16'h0025, 8'h00, '0);
		add_row(OP_RDROM, 16'h4000, 16'h0000, 8'h00, 22'h04a000); // half-bank 74
		add_row(OP_RDROM, 16'h0123, 16'h0000, 8'h00, 22'h000091); // high lane
		add_row(OP_RD,    16'ha000, 16'h0000, 8'hff, '0); // ram closed
		add_row(OP_WR,    16'h0000, 16'h000a, 8'h00, '0);
		add_row(OP_RAMWR, 16'ha010, 16'h0000, 8'h00, '0);
		add_row(OP_RAMRD, 16'ha010, 16'h0000, 8'h00, '0);
		add_row(OP_WR,    16'h6000, 16'h0001, 8'h00, '0); // ram banking mode
		add_row(OP_RAMWR, 16'ha020, 16'h0001, 8'h00, '0); // ram bank 1
		add_row(OP_WR,    16'h4000, 16'h0002, 8'h00, '0);
		add_row(OP_RAMWR, 16'ha020, 16'h0002, 8'h00, '0); // ram bank 2
		add_row(OP_RAMRD, 16'ha020, 16'h0002, 8'h00, '0);
		add_row(OP_WR,    16'h4000, 16'h0001, 8'h00, '0);
		add_row(OP_RAMRD, 16'ha020, 16'h0001, 8'h00, '0); // bank 1 kept its byte
		add_row(OP_IMAGE, 16'h0019, 16'h0408, 8'h00, '0); // mbc5 with 512 banks
		add_row(OP_WR,    16'h3000, 16'h0001, 8'h00, '0); // bank bit 8
		add_row(OP_WR,    16'h2000, 16'h0023, 8'h00, '0);
		add_row(OP_RDROM, 16'h7ffe, 16'h0000, 8'h00, 22'h247fff);
		add_row(OP_WR,    16'h3000, 16'h0000, 8'h00, '0);
		add_row(OP_WR,    16'h2000, 16'h0000, 8'h00, '0); // bank 0 is legal here
		add_row(OP_RDROM, 16'h4002, 16'h0000, 8'h00, 22'h000001);
		add_row(OP_IMAGE, 16'hc013, 16'h0305, 8'h01, '0); // mbc3
		add_row(OP_WR,    16'h0000, 16'h000a, 8'h00, '0);
		add_row(OP_RAMWR, 16'ha040, 16'h0003, 8'h00, '0);
		add_row(OP_WR,    16'h4000, 16'h0008, 8'h00, '0); // rtc register select
		add_row(OP_RD,    16'ha040, 16'h0000, 8'h00, '0);
		add_row(OP_IMAGE, 16'h0005, 16'h0000, 8'h00, '0); // mbc2
		add_row(OP_WR,    16'h0000, 16'h000a, 8'h00, '0);
		add_row(OP_WR,    16'ha005, 16'h003c, 8'h00, '0);
		add_row(OP_RD,    16'ha005, 16'h0000, 8'hfc, '0); // upper nibble reads as ones
	endtask

	initial begin
		rng_state   = 32'd89;
		reset       = 1'b1;
		load_active = 1'b0;
		load_wr     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		cart_addr   = '0;
		cart_rd     = 1'b0;
		cart_wr     = 1'b0;
		cart_di     = '0;
		build_table();
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		for (int i = 0; i < op_q.size(); i++)
			apply_row(op_q[i], addr_q[i], data_q[i], exp_q[i], ra_q[i]);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- gb_cart_mapper.f
hdl/cart_pkg.sv
hdl/cart_header.sv
hdl/mbc_regs.sv
hdl/bank_map.sv
hdl/cart_ram.sv
hdl/gb_cart_mapper.sv
sim/tb_gb_cart_mapper.sv
